// ==== src/timerA_macros.svh ====
`ifndef TIMERA_MACROS_SVH
`define TIMERA_MACROS_SVH

// channel count, decode works for 1 to 7
`define CCM_COUNT 3

// register map, channel n at base + 2n
`define TACTL_ADDR   16'h0160
`define TAR_ADDR     16'h0170
`define TACCTL0_ADDR 16'h0162
`define TACCR0_ADDR  16'h0172
`define TAIV_ADDR    16'h012E

// field positions in TACTL / TACCTLn
`define CCIE_BIT  4
`define CCIFG_BIT 0
`define TAIE_BIT  1
`define TAIFG_BIT 0
`define TACLR_BIT 2
`define MC_LSB    4 // two-bit mode field

`endif

// ==== src/timerTypesPkg.sv ====
`include "timerA_macros.svh"

package timerTypesPkg;

    // counter and compare values
    typedef logic [15:0] tarT;

    // interrupt vector as seen in TAIV
    typedef logic [3:0] ivT;

    // one bit per compare channel
    typedef logic [`CCM_COUNT-1:0] ccMaskT;

    // MC field encoding
    typedef enum logic [1:0] {
        modeStop   = 2'b00,
        modeUp     = 2'b01, // up to TACCR0
        modeCont   = 2'b10, // up to FFFF
        modeUpDown = 2'b11  // up to TACCR0, then back to 0
    } timerModeT;

endpackage

// ==== src/busTypesPkg.sv ====
package busTypesPkg;

    // peripheral bus, byte address
    typedef logic [15:0] addrT;

    // word-wide data in both directions
    typedef logic [15:0] dataT;

endpackage

// ==== src/timerIntIf.sv ====
`timescale 1ns/1ps

interface timerIntIf import timerTypesPkg::*; ();

    logic   taifg;    // timer block overflow flag
    logic   taie;     // its enable
    ccMaskT ccifg;    // compare flags, one per channel
    ccMaskT ccie;     // compare enables
    logic   taifgClr; // one-cycle clear from vector unit
    ccMaskT ccifgClr;

    // flag owners: timer block and each compare channel
    modport flagSrc (
        output taifg, taie, ccifg, ccie,
        input  taifgClr, ccifgClr
    );

    modport vecUnit (
        input  taifg, taie, ccifg, ccie,
        output taifgClr, ccifgClr
    );

endinterface

// ==== src/timerBlock.sv ====
`timescale 1ns/1ps
`include "timerA_macros.svh"

module timerBlock import timerTypesPkg::*, busTypesPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic tactlWr,
    input  logic tarWr,
    input  dataT wrData,
    input  tarT  ccr0,   // period in up and up/down mode
    output tarT  tar,
    output dataT tactl,
    timerIntIf.flagSrc intBus
);

    timerModeT mode;
    logic      taieQ;
    logic      taifgQ;
    logic      dirDown;  // up/down mode, high while counting down
    tarT       tarNext;
    logic      dirNext;
    logic      taifgSet; // wrap or return to zero

    // ******************************
    // next count
    // ******************************
    always_comb begin
        tarNext  = tar;
        dirNext  = dirDown;
        taifgSet = 1'b0;
        case (mode)
            modeUp: begin
                if (tar >= ccr0) begin // catches ccr0 moved below tar
                    tarNext  = '0;
                    taifgSet = 1'b1;
                end else begin
                    tarNext = tar + 1'b1;
                end
            end
            modeCont: begin
                tarNext  = tar + 1'b1;
                taifgSet = (tar == 16'hFFFF); // wraps to 0
            end
            modeUpDown: begin
                if (!dirDown) begin
                    if (tar >= ccr0 && tar != '0) begin
                        dirNext = 1'b1; // turn at the top
                        tarNext = tar - 1'b1;
                    end else begin
                        tarNext = tar + 1'b1;
                    end
                end else begin
                    tarNext = tar - 1'b1;
                    if (tar == 16'd1) begin // about to reach zero
                        taifgSet = 1'b1;
                        dirNext  = 1'b0;
                    end
                end
            end
            default: ; // stopped, hold
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mode    <= modeStop;
            taieQ   <= 1'b0;
            taifgQ  <= 1'b0;
            tar     <= '0;
            dirDown <= 1'b0;
        end else begin
            if (tactlWr) begin
                mode  <= timerModeT'(wrData[`MC_LSB +: 2]);
                taieQ <= wrData[`TAIE_BIT];
            end
            // set wins over any clear
            if (taifgSet)
                taifgQ <= 1'b1;
            else if (tactlWr)
                taifgQ <= wrData[`TAIFG_BIT];
            else if (intBus.taifgClr)
                taifgQ <= 1'b0;
            // counter
            if (tactlWr && wrData[`TACLR_BIT]) begin
                tar     <= '0;
                dirDown <= 1'b0;
            end else if (tarWr) begin
                tar <= wrData; // software load
            end else begin
                tar     <= tarNext;
                dirDown <= dirNext;
            end
        end
    end

    always_comb begin
        tactl                  = '0; // TACLR always reads back 0
        tactl[`MC_LSB +: 2]    = mode;
        tactl[`TAIE_BIT]       = taieQ;
        tactl[`TAIFG_BIT]      = taifgQ;
    end

    assign intBus.taifg = taifgQ;
    assign intBus.taie  = taieQ;

endmodule

// ==== src/captureCompare.sv ====
`timescale 1ns/1ps
`include "timerA_macros.svh"

module captureCompare import timerTypesPkg::*, busTypesPkg::*; #(
    parameter int chan = 0 // channel index, picks the flag bit
) (
    input  logic clk,
    input  logic rstN,
    input  logic counting, // mode is not stop
    input  tarT  tar,
    input  logic ccrWr,
    input  logic cctlWr,
    input  dataT wrData,
    input  logic autoClr,  // int0 acknowledge on channel 0
    output tarT  ccr,
    output dataT cctl,
    timerIntIf.flagSrc intBus
);

    logic ccieQ;
    logic ccifgQ;
    logic hit;

    assign hit = counting && (tar == ccr); // flag lands on the next edge

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ccr    <= '0;
            ccieQ  <= 1'b0;
            ccifgQ <= 1'b0;
        end else begin
            if (ccrWr)
                ccr <= wrData;
            if (cctlWr)
                ccieQ <= wrData[`CCIE_BIT];
            if (hit)
                ccifgQ <= 1'b1; // set beats clear
            else if (cctlWr)
                ccifgQ <= wrData[`CCIFG_BIT];
            else if (intBus.ccifgClr[chan] || autoClr)
                ccifgQ <= 1'b0;
        end
    end

    always_comb begin
        cctl             = '0;
        cctl[`CCIE_BIT]  = ccieQ;
        cctl[`CCIFG_BIT] = ccifgQ;
    end

    // this channel's bits only
    assign intBus.ccifg[chan] = ccifgQ;
    assign intBus.ccie[chan]  = ccieQ;

endmodule

// ==== src/timerAInt.sv ====
`timescale 1ns/1ps
`include "timerA_macros.svh"

module timerAInt import timerTypesPkg::*; (
    input  ivT   ivCurrent, // vector held in TAIV
    input  logic ivRead,    // TAIV read this cycle
    input  logic int0Ack,
    output ivT   ivNew,
    output logic int1,
    output logic int0,
    timerIntIf.vecUnit intBus
);

    // ******************************
    // priority encode
    // ******************************

    // walk from lowest priority up, later hits overwrite
    always_comb begin
        ivNew = '0;
        if (intBus.taifg && intBus.taie)
            ivNew = 4'hE;
        for (int i = `CCM_COUNT - 1; i > 0; i--) begin
            if (intBus.ccifg[i] && intBus.ccie[i])
                ivNew = ivT'(2 * i);
        end
    end

    assign int1 = (ivNew != '0);                      // any vectored source
    assign int0 = intBus.ccifg[0] && intBus.ccie[0];  // channel 0 has its own line

    // ******************************
    // flag clears
    // ******************************
    always_comb begin
        intBus.taifgClr    = 1'b0;
        intBus.ccifgClr    = '0;
        intBus.ccifgClr[0] = int0Ack; // acknowledge clears CCIFG0
        if (ivRead) begin
            // clear what the stored vector names, not the new one
            if (ivCurrent == 4'hE) begin
                intBus.taifgClr = 1'b1;
            end else begin
                for (int i = 1; i < `CCM_COUNT; i++) begin
                    if (ivCurrent == ivT'(2 * i))
                        intBus.ccifgClr[i] = 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/timerARegs.sv ====
`timescale 1ns/1ps
`include "timerA_macros.svh"

module timerARegs import timerTypesPkg::*, busTypesPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  addrT   addr,
    input  dataT   wrData,
    input  logic   wr,
    input  logic   rd,
    input  tarT    tar,
    input  dataT   tactl,
    input  dataT   ccr [`CCM_COUNT],
    input  dataT   cctl [`CCM_COUNT],
    input  ivT     ivNew,
    output logic   tactlWr,
    output logic   tarWr,
    output ccMaskT ccrWr,
    output ccMaskT cctlWr,
    output ivT     ivCurrent,
    output logic   ivRead,
    output dataT   rdData
);

    dataT rdMux;

    // ******************************
    // write decode
    // ******************************
    always_comb begin
        tactlWr = wr && (addr == `TACTL_ADDR);
        tarWr   = wr && (addr == `TAR_ADDR);
        for (int i = 0; i < `CCM_COUNT; i++) begin
            ccrWr[i]  = wr && (addr == addrT'(`TACCR0_ADDR + 2 * i));
            cctlWr[i] = wr && (addr == addrT'(`TACCTL0_ADDR + 2 * i));
        end
    end

    assign ivRead = rd && (addr == `TAIV_ADDR); // clears the named flag next edge

    // ******************************
    // read path
    // ******************************
    always_comb begin
        rdMux = '0; // unmapped reads as zero
        if (addr == `TACTL_ADDR)
            rdMux = tactl;
        else if (addr == `TAR_ADDR)
            rdMux = tar;
        else if (addr == `TAIV_ADDR)
            rdMux = dataT'(ivCurrent); // vector before the clear
        for (int i = 0; i < `CCM_COUNT; i++) begin
            if (addr == addrT'(`TACCR0_ADDR + 2 * i))
                rdMux = ccr[i];
            if (addr == addrT'(`TACCTL0_ADDR + 2 * i))
                rdMux = cctl[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdData    <= '0;
            ivCurrent <= '0;
        end else begin
            if (rd)
                rdData <= rdMux; // held until next read
            ivCurrent <= ivNew;  // TAIV tracks the encoder, one cycle late
        end
    end

endmodule

// ==== src/timerA.sv ====
`timescale 1ns/1ps
`include "timerA_macros.svh"

module timerA import timerTypesPkg::*, busTypesPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  addrT addr,
    input  dataT wrData,
    input  logic wr,
    input  logic rd,
    input  logic int0Ack,
    output dataT rdData,
    output logic int1,
    output logic int0
);

    timerIntIf intBus ();

    tarT    tar;
    dataT   tactl;
    dataT   ccrVal [`CCM_COUNT];
    dataT   cctlVal [`CCM_COUNT];
    logic   tactlWr, tarWr, ivRead, counting;
    ccMaskT ccrWr, cctlWr;
    ivT     ivNew, ivCurrent;

    assign counting = (timerModeT'(tactl[`MC_LSB +: 2]) != modeStop);

    timerBlock uTimer (
        .clk, .rstN, .tactlWr, .tarWr, .wrData,
        .ccr0(ccrVal[0]), .tar, .tactl, .intBus(intBus.flagSrc)
    );

    // ******************************
    // compare channels
    // ******************************
    for (genvar i = 0; i < `CCM_COUNT; i++) begin : genCcm
        captureCompare #(.chan(i)) uCcm (
            .clk, .rstN, .counting, .tar, .ccrWr(ccrWr[i]), .cctlWr(cctlWr[i]),
            .wrData, .autoClr((i == 0) ? int0Ack : 1'b0), // ack only on channel 0
            .ccr(ccrVal[i]), .cctl(cctlVal[i]), .intBus(intBus.flagSrc)
        );
    end

    timerAInt uInt (
        .ivCurrent, .ivRead, .int0Ack, .ivNew, .int1, .int0, .intBus(intBus.vecUnit)
    );

    timerARegs uRegs (
        .clk, .rstN, .addr, .wrData, .wr, .rd, .tar, .tactl,
        .ccr(ccrVal), .cctl(cctlVal), .ivNew, .tactlWr, .tarWr,
        .ccrWr, .cctlWr, .ivCurrent, .ivRead, .rdData
    );

endmodule

// ==== testbench/timerA_tb.sv ====
`timescale 1ns/1ps
`include "timerA_macros.svh"

module timerA_tb import timerTypesPkg::*, busTypesPkg::*; ();

    localparam int clkPeriod    = 10;
    localparam int waitLimit    = 100;  // cycles allowed for a timer interrupt
    localparam int patternCount = 8;
    localparam int upPeriod     = 40;   // TACCR0 + 1 in up mode
    localparam int testCycles   = 5 + 30 + 20 + patternCount * 40 + 20 + 2 * (waitLimit + 40);
    localparam int marginCycles = 200;

    logic clk, rstN, wr, rd, int0Ack, int1, int0;
    addrT addr;
    dataT wrData, rdData;

    // software view of the flags, valid while the timer is stopped
    ccMaskT modelFg, modelIe;
    logic   modelTaifg, modelTaie, trackModel;
    logic [31:0] seed = 32'hac97_2668;
    int   cycleCount = 0;
    int   ivSeq = 0;      // bumped per TAIV read
    int   ivSeen = 0;
    dataT ivGot, ivExp;

    timerA uut (
        .clk, .rstN, .addr, .wrData, .wr, .rd, .int0Ack, .rdData, .int1, .int0
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) cycleCount <= cycleCount + 1;

    // ******************************
    // reference model
    // ******************************
    function automatic ivT expectedIv(input ccMaskT fg, input ccMaskT ie,
                                      input logic tfg, input logic tie);
        ivT   v;
        logic found;
        v     = 4'h0;
        found = 1'b0;
        for (int n = 1; n < `CCM_COUNT; n++) begin  // lowest channel wins
            if (!found && fg[n] && ie[n]) begin
                v     = 4'(2 * n);
                found = 1'b1;
            end
        end
        if (!found && tfg && tie)
            v = 4'hE;
        return v;
    endfunction

    function automatic logic [31:0] nextRandom();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic addrT channelAddr(input addrT base, input int n);
        return addrT'(base + 2 * n); // channel n at base + 2n
    endfunction

    task automatic abortRun();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input dataT got, input dataT exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got 0x%04h expected 0x%04h", name, got, exp);
            abortRun();
        end
    endtask

    // compare process, TAIV reads and interrupt levels
    always @(negedge clk) begin
        ivT modelIv;
        modelIv = expectedIv(modelFg, modelIe, modelTaifg, modelTaie);
        if (ivSeq != ivSeen) begin
            ivSeen = ivSeq;
            assert (ivGot === ivExp) else begin
                $display("[FAIL] TAIV got 0x%04h expected 0x%04h", ivGot, ivExp);
                abortRun();
            end
        end
        if (trackModel) begin
            assert (int1 === (modelIv != 4'h0)) else begin
                $display("[FAIL] int1 got 0x%0h expected 0x%0h", int1, modelIv != 4'h0);
                abortRun();
            end
            assert (int0 === (modelFg[0] && modelIe[0])) else begin
                $display("[FAIL] int0 got 0x%0h expected 0x%0h", int0,
                         modelFg[0] && modelIe[0]);
                abortRun();
            end
        end
    end

    // ******************************
    // bus tasks
    // ******************************
    task automatic idleCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic busWrite(input addrT a, input dataT d);
        addr   = a;
        wrData = d;
        wr     = 1'b1;
        idleCycle();
        wr     = 1'b0;
    endtask

    task automatic busRead(input addrT a, output dataT d);
        addr = a;
        rd   = 1'b1;
        idleCycle();
        rd   = 1'b0;
        d    = rdData;  // registered one edge after rd
    endtask

    task automatic writeChannelCtl(input int n, input logic ie, input logic fg);
        dataT d;
        d             = '0;
        d[`CCIE_BIT]  = ie;
        d[`CCIFG_BIT] = fg;
        busWrite(channelAddr(`TACCTL0_ADDR, n), d);
        modelIe[n] = ie;
        modelFg[n] = fg;
    endtask

    task automatic writeTimerCtl(input timerModeT mode, input logic tie, input logic tfg,
                                 input logic clr);
        dataT d;
        d                   = '0;
        d[`MC_LSB +: 2]     = mode;
        d[`TAIE_BIT]        = tie;
        d[`TAIFG_BIT]       = tfg;
        d[`TACLR_BIT]       = clr;
        busWrite(`TACTL_ADDR, d);
        modelTaie  = tie;
        modelTaifg = tfg;
    endtask

    // idle first so TAIV has caught up with the last flag change
    task automatic readIv(input ivT exp);
        dataT d;
        idleCycle();
        busRead(`TAIV_ADDR, d);
        ivGot = d;
        ivExp = dataT'(exp);
        ivSeq = ivSeq + 1;
    endtask

    task automatic readIvTracked();
        ivT exp;
        exp = expectedIv(modelFg, modelIe, modelTaifg, modelTaie);
        readIv(exp);
        if (exp == 4'hE)
            modelTaifg = 1'b0;
        for (int n = 1; n < `CCM_COUNT; n++) begin
            if (exp == 4'(2 * n))
                modelFg[n] = 1'b0;  // named flag is gone
        end
    endtask

    task automatic waitForInt1(output int rise);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!int1) begin
            waited++;
            if (waited > waitLimit) begin
                $display("int1 did not rise within %0d cycles", waitLimit);
                abortRun();
            end
            @(negedge clk);
        end
        rise = cycleCount;
        idleCycle();
    endtask

    task automatic stopAndClear();
        writeTimerCtl(modeStop, 1'b0, 1'b0, 1'b1);
        for (int n = 0; n < `CCM_COUNT; n++)
            writeChannelCtl(n, 1'b0, 1'b0);
        writeTimerCtl(modeStop, 1'b0, 1'b0, 1'b0); // drops a TAIFG set while stopping
        trackModel = 1'b1;
    endtask

    initial begin
        #(clkPeriod * (testCycles + marginCycles));
        $display("watchdog expired after %0d cycles", testCycles + marginCycles);
        abortRun();
    end

    // ******************************
    // test sequence
    // ******************************
    initial begin
        logic [31:0] r;
        dataT d;
        dataT ccrExp [`CCM_COUNT];
        int   riseCycle;
        logic refired;
        rstN = 1'b0;
        addr = '0;
        wrData = '0;
        wr = 1'b0;
        rd = 1'b0;
        int0Ack = 1'b0;
        modelFg = '0;
        modelIe = '0;
        modelTaifg = 1'b0;
        modelTaie = 1'b0;
        trackModel = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        trackModel = 1'b1;

        // reset values
        busRead(`TACTL_ADDR, d);
        checkValue("TACTL", d, 16'h0000);
        busRead(`TAR_ADDR, d);
        checkValue("TAR", d, 16'h0000);
        for (int n = 0; n < `CCM_COUNT; n++) begin
            busRead(channelAddr(`TACCR0_ADDR, n), d);
            checkValue("TACCRn", d, 16'h0000);
            busRead(channelAddr(`TACCTL0_ADDR, n), d);
            checkValue("TACCTLn", d, 16'h0000);
        end
        readIvTracked();

        // register readback, timer stopped
        for (int n = 0; n < `CCM_COUNT; n++) begin
            r = nextRandom();
            ccrExp[n] = r[15:0];
            busWrite(channelAddr(`TACCR0_ADDR, n), r[15:0]);
            writeChannelCtl(n, r[16], 1'b0);
        end
        for (int n = 0; n < `CCM_COUNT; n++) begin
            busRead(channelAddr(`TACCR0_ADDR, n), d);
            checkValue("TACCRn", d, ccrExp[n]);
            busRead(channelAddr(`TACCTL0_ADDR, n), d);
            checkValue("TACCTLn", d, dataT'(modelIe[n]) << `CCIE_BIT);
        end

        // random flag patterns, each walk ends at 0
        for (int p = 0; p < patternCount; p++) begin
            r = nextRandom();
            for (int n = 0; n < `CCM_COUNT; n++)
                writeChannelCtl(n, r[n], r[8 + n]);
            writeTimerCtl(modeStop, r[16], r[17], 1'b0);
            repeat (`CCM_COUNT + 1) readIvTracked();
        end

        // int0 and its acknowledge
        writeChannelCtl(0, 1'b1, 1'b1);
        checkValue("int0", dataT'(int0), 16'h0001);
        int0Ack = 1'b1;
        idleCycle();
        int0Ack = 1'b0;
        modelFg[0] = 1'b0;
        checkValue("int0", dataT'(int0), 16'h0000);
        busRead(`TACCTL0_ADDR, d);
        checkValue("TACCTL0", d, dataT'(1) << `CCIE_BIT);

        // continuous mode, compare on channel 1
        trackModel = 1'b0;
        for (int n = 0; n < `CCM_COUNT; n++) begin
            busWrite(channelAddr(`TACCR0_ADDR, n), (n == 1) ? 16'd20 : 16'hFFF0);
            writeChannelCtl(n, n == 1, 1'b0);
        end
        writeTimerCtl(modeCont, 1'b0, 1'b0, 1'b1);
        waitForInt1(riseCycle);
        readIv(4'h2);
        busRead(channelAddr(`TACCTL0_ADDR, 1), d);
        checkValue("TACCTL1", d, dataT'(1) << `CCIE_BIT);
        stopAndClear();

        // up mode, overflow vector
        trackModel = 1'b0;
        busWrite(`TACCR0_ADDR, 16'(upPeriod - 1));
        writeTimerCtl(modeUp, 1'b1, 1'b0, 1'b1);
        waitForInt1(riseCycle);
        readIv(4'hE);
        refired = (cycleCount >= riseCycle + upPeriod); // next wrap before the sample
        readIv(refired ? 4'hE : 4'h0);
        stopAndClear();
        readIvTracked();
        idleCycle(); // last TAIV read is compared at the negedge in between

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+src
src/timerTypesPkg.sv
src/busTypesPkg.sv
src/timerIntIf.sv
src/timerBlock.sv
src/captureCompare.sv
src/timerAInt.sv
src/timerARegs.sv
src/timerA.sv
testbench/timerA_tb.sv

// ==== Makefile ====
TOP = timerA_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "All tests passed!" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
